// ==== hw/cgra_consts.svh ====
`ifndef CGRA_CONSTS_SVH
`define CGRA_CONSTS_SVH

// Target codes, compared against the upper address half.
`define CFG_SB  16'd7
`define CFG_CB0 16'd6
`define CFG_CB1 16'd5
`define CFG_CLB 16'd4

// Side numbering, also the index into the per-side track arrays.
`define SIDE_N 0
`define SIDE_W 1
`define SIDE_S 2
`define SIDE_E 3
`define NUM_SIDES 4

`define NUM_TRACKS 4

// Address fields.
`define TILE_ID_LSB 0
`define TILE_ID_MSB 15
`define TARGET_LSB 16
`define TARGET_MSB 31

`endif

// ==== hw/cgra_pkg.sv ====
`include "cgra_consts.svh"

package cgra_pkg;

	// One route select per switch box output.
	typedef logic [1:0] sb_sel_t;

	// Connect box track select, 0..3 inputs and 4..7 outputs.
	typedef logic [2:0] cb_sel_t;

	// Compute block opcode: AND, OR, XOR, NAND.
	typedef logic [1:0] clb_op_t;

	typedef struct packed {
		logic [28:0] unused;
		cb_sel_t     sel;
	} cb_cfg_t;

	typedef struct packed {
		logic [29:0] unused;
		clb_op_t     op;
	} clb_cfg_t;

	// Select for output side s, track t sits at index NUM_TRACKS*s + t.
	typedef sb_sel_t [`NUM_SIDES*`NUM_TRACKS-1:0] sb_cfg_t;

	// One 32-bit config word, decoded by the addressed target.
	typedef union packed {
		sb_cfg_t  sb;
		cb_cfg_t  cb;
		clb_cfg_t clb;
	} cfg_word_u;

endpackage

// ==== hw/connect_box.sv ====
`include "cgra_consts.svh"

module connect_box (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      config_en,
	input  cgra_pkg::cfg_word_u       config_data,
	input  logic [2*`NUM_TRACKS-1:0]  tracks_in,
	output logic                      block_out
);

	import cgra_pkg::*;

	cb_sel_t sel_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= '0; // Track 0 after reset.
		end else if (config_en) begin
			sel_q <= config_data.cb.sel;
		end
	end

	// Low half is the side's inputs, high half the same side's outputs.
	assign block_out = tracks_in[sel_q];

	a_sel_known : assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(sel_q)
	) else $error("connect_box: select register unknown");

endmodule

// ==== hw/switch_box.sv ====
`include "cgra_consts.svh"

module switch_box (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    config_en,
	input  cgra_pkg::cfg_word_u     config_data,
	input  logic [`NUM_TRACKS-1:0]  in_n,
	input  logic [`NUM_TRACKS-1:0]  in_w,
	input  logic [`NUM_TRACKS-1:0]  in_s,
	input  logic [`NUM_TRACKS-1:0]  in_e,
	output logic [`NUM_TRACKS-1:0]  out_n,
	output logic [`NUM_TRACKS-1:0]  out_w,
	output logic [`NUM_TRACKS-1:0]  out_s,
	output logic [`NUM_TRACKS-1:0]  out_e,
	input  logic                    pe_output
);

	import cgra_pkg::*;

	cfg_word_u cfg_q;

	logic [`NUM_TRACKS-1:0] side_in  [`NUM_SIDES];
	logic [`NUM_TRACKS-1:0] side_out [`NUM_SIDES];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q <= '0; // All routes straight through.
		end else if (config_en) begin
			cfg_q <= config_data;
		end
	end

	assign side_in[`SIDE_N] = in_n;
	assign side_in[`SIDE_W] = in_w;
	assign side_in[`SIDE_S] = in_s;
	assign side_in[`SIDE_E] = in_e;

	// Each output picks the opposite side, one of the two adjacent
	// sides, or the compute block result.
	for (genvar s = 0; s < `NUM_SIDES; s++) begin : g_side
		for (genvar t = 0; t < `NUM_TRACKS; t++) begin : g_track
			sb_sel_t sel;

			assign sel = cfg_q.sb[`NUM_TRACKS*s+t];

			assign side_out[s][t] =
				(sel == 2'd0) ? side_in[(s+2)%`NUM_SIDES][t] : // Opposite side.
				(sel == 2'd1) ? side_in[(s+1)%`NUM_SIDES][t] :
				(sel == 2'd2) ? side_in[(s+3)%`NUM_SIDES][t] :
				pe_output;
		end
	end

	assign out_n = side_out[`SIDE_N];
	assign out_w = side_out[`SIDE_W];
	assign out_s = side_out[`SIDE_S];
	assign out_e = side_out[`SIDE_E];

	// Known inputs must give known outputs, which also covers the select registers.
	a_out_known : assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown({in_n, in_w, in_s, in_e, pe_output}) |->
			!$isunknown({out_n, out_w, out_s, out_e})
	) else $error("switch_box: unknown output with known inputs");

endmodule

// ==== hw/clb.sv ====
`include "cgra_consts.svh"

module clb (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 config_en,
	input  cgra_pkg::cfg_word_u  config_data,
	input  logic                 in0,
	input  logic                 in1,
	output logic                 out
);

	import cgra_pkg::*;

	clb_op_t op_q;
	logic    result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q <= '0; // AND.
		end else if (config_en) begin
			op_q <= config_data.clb.op;
		end
	end

	always_comb begin
		case (op_q)
			2'd0:    result = in0 & in1;
			2'd1:    result = in0 | in1;
			2'd2:    result = in0 ^ in1;
			default: result = ~(in0 & in1); // NAND.
		endcase
	end

	// Registered result breaks loops through the tile's own tracks
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out <= 1'b0;
		end else begin
			out <= result;
		end
	end

endmodule

// ==== hw/pe_tile.sv ====
`include "cgra_consts.svh"

module pe_tile #(
	parameter logic [15:0] TILE_ID = 16'd1
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [31:0]             config_addr,
	input  cgra_pkg::cfg_word_u     config_data,
	input  logic [`NUM_TRACKS-1:0]  in_n,
	input  logic [`NUM_TRACKS-1:0]  in_w,
	input  logic [`NUM_TRACKS-1:0]  in_s,
	input  logic [`NUM_TRACKS-1:0]  in_e,
	output logic [`NUM_TRACKS-1:0]  out_n,
	output logic [`NUM_TRACKS-1:0]  out_w,
	output logic [`NUM_TRACKS-1:0]  out_s,
	output logic [`NUM_TRACKS-1:0]  out_e
);

	logic        id_hit;
	logic [15:0] target;
	logic        config_en_sb;
	logic        config_en_cb0;
	logic        config_en_cb1;
	logic        config_en_clb;
	logic        op_0;
	logic        op_1;
	logic        pe_output;

	// Tile ids start at 1, so the idle address never matches.
	assign id_hit = (config_addr[`TILE_ID_MSB:`TILE_ID_LSB] == TILE_ID);
	assign target = config_addr[`TARGET_MSB:`TARGET_LSB];

	assign config_en_sb  = id_hit && (target == `CFG_SB);
	assign config_en_cb0 = id_hit && (target == `CFG_CB0);
	assign config_en_cb1 = id_hit && (target == `CFG_CB1);
	assign config_en_clb = id_hit && (target == `CFG_CLB);

	connect_box cb0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_en   (config_en_cb0),
		.config_data (config_data),
		.tracks_in   ({out_n, in_n}), // North side.
		.block_out   (op_0)
	);

	connect_box cb1 (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_en   (config_en_cb1),
		.config_data (config_data),
		.tracks_in   ({out_w, in_w}), // West side.
		.block_out   (op_1)
	);

	switch_box sb (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_en   (config_en_sb),
		.config_data (config_data),
		.in_n        (in_n),
		.in_w        (in_w),
		.in_s        (in_s),
		.in_e        (in_e),
		.out_n       (out_n),
		.out_w       (out_w),
		.out_s       (out_s),
		.out_e       (out_e),
		.pe_output   (pe_output)
	);

	clb compute_block (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_en   (config_en_clb),
		.config_data (config_data),
		.in0         (op_0),
		.in1         (op_1),
		.out         (pe_output)
	);

	a_one_target : assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0({config_en_sb, config_en_cb0, config_en_cb1, config_en_clb})
	) else $error("pe_tile %0d: more than one config enable", TILE_ID);

endmodule

// ==== hw/cgra_array.sv ====
`include "cgra_consts.svh"

module cgra_array (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [31:0]               config_addr,
	input  logic [31:0]               config_data,
	input  logic [2*`NUM_TRACKS-1:0]  north_in,
	input  logic [2*`NUM_TRACKS-1:0]  west_in,
	output logic [2*`NUM_TRACKS-1:0]  south_out,
	output logic [2*`NUM_TRACKS-1:0]  east_out
);

	// Tile numbering: 1 and 2 on row 0, 3 and 4 on row 1.
	logic [`NUM_TRACKS-1:0] s_1_3; // Tile 1 south to tile 3 north.
	logic [`NUM_TRACKS-1:0] n_3_1;
	logic [`NUM_TRACKS-1:0] s_2_4;
	logic [`NUM_TRACKS-1:0] n_4_2;
	logic [`NUM_TRACKS-1:0] e_1_2; // Tile 1 east to tile 2 west.
	logic [`NUM_TRACKS-1:0] w_2_1;
	logic [`NUM_TRACKS-1:0] e_3_4;
	logic [`NUM_TRACKS-1:0] w_4_3;

	pe_tile #(.TILE_ID(16'd1)) tile_1 (
		.clk (clk), .rst_n (rst_n),
		.config_addr (config_addr), .config_data (config_data),
		.in_n  (north_in[`NUM_TRACKS-1:0]),
		.in_w  (west_in[`NUM_TRACKS-1:0]),
		.in_s  (n_3_1),
		.in_e  (w_2_1),
		.out_n (),
		.out_w (),
		.out_s (s_1_3),
		.out_e (e_1_2)
	);

	pe_tile #(.TILE_ID(16'd2)) tile_2 (
		.clk (clk), .rst_n (rst_n),
		.config_addr (config_addr), .config_data (config_data),
		.in_n  (north_in[2*`NUM_TRACKS-1:`NUM_TRACKS]),
		.in_w  (e_1_2),
		.in_s  (n_4_2),
		.in_e  ('0), // Array edge.
		.out_n (),
		.out_w (w_2_1),
		.out_s (s_2_4),
		.out_e (east_out[`NUM_TRACKS-1:0])
	);

	pe_tile #(.TILE_ID(16'd3)) tile_3 (
		.clk (clk), .rst_n (rst_n),
		.config_addr (config_addr), .config_data (config_data),
		.in_n  (s_1_3),
		.in_w  (west_in[2*`NUM_TRACKS-1:`NUM_TRACKS]),
		.in_s  ('0),
		.in_e  (w_4_3),
		.out_n (n_3_1),
		.out_w (),
		.out_s (south_out[`NUM_TRACKS-1:0]),
		.out_e (e_3_4)
	);

	pe_tile #(.TILE_ID(16'd4)) tile_4 (
		.clk (clk), .rst_n (rst_n),
		.config_addr (config_addr), .config_data (config_data),
		.in_n  (s_2_4),
		.in_w  (e_3_4),
		.in_s  ('0),
		.in_e  ('0),
		.out_n (n_4_2),
		.out_w (w_4_3),
		.out_s (south_out[2*`NUM_TRACKS-1:`NUM_TRACKS]),
		.out_e (east_out[2*`NUM_TRACKS-1:`NUM_TRACKS])
	);

endmodule

// ==== testbench/tb_route_model.sv ====
`include "cgra_consts.svh"

module tb_route_model (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0]          config_addr,
	input  cgra_pkg::cfg_word_u  config_data,
	input  logic [7:0]           north_in,
	input  logic [7:0]           west_in,
	output logic [7:0]           exp_south,
	output logic [7:0]           exp_east
);
	timeunit 1ns;
	timeprecision 1ps;

	import cgra_pkg::*;

	sb_cfg_t    sb_cfg  [4]; // Shadow copies, index is tile id minus 1.
	cb_sel_t    cb0_sel [4];
	cb_sel_t    cb1_sel [4];
	clb_op_t    op      [4];
	logic       pe      [4];
	logic       op_a    [4];
	logic       op_b    [4];
	logic       addr_hit;
	logic [1:0] addr_tile;

	assign addr_hit  = (config_addr[15:0] >= 16'd1) && (config_addr[15:0] <= 16'd4);
	assign addr_tile = 2'(config_addr[15:0] - 16'd1);

	// Truth table per opcode, indexed by {a, b}.
	function automatic logic logic_op(input clb_op_t code, input logic a, input logic b);
		logic [3:0] table_bits;
		case (code)
			2'd0:    table_bits = 4'b1000;
			2'd1:    table_bits = 4'b1110;
			2'd2:    table_bits = 4'b0110;
			default: table_bits = 4'b0111;
		endcase
		return table_bits[{a, b}];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				sb_cfg[i]  <= '0;
				cb0_sel[i] <= '0;
				cb1_sel[i] <= '0;
				op[i]      <= '0;
				pe[i]      <= 1'b0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				pe[i] <= logic_op(op[i], op_a[i], op_b[i]);
			end
			if (addr_hit) begin
				case (config_addr[31:16])
					`CFG_SB:  sb_cfg[addr_tile]  <= config_data.sb;
					`CFG_CB0: cb0_sel[addr_tile] <= config_data.cb.sel;
					`CFG_CB1: cb1_sel[addr_tile] <= config_data.cb.sel;
					`CFG_CLB: op[addr_tile]      <= config_data.clb.op;
					default:  ;
				endcase
			end
		end
	end

	// Selects are 0 or 3 here, so repeated passes settle without loops.
	always_comb begin
		logic [3:0] tin  [4][4];
		logic [3:0] tout [4][4];
		int         r;
		int         c;
		for (int k = 0; k < 4; k++) begin
			for (int s = 0; s < 4; s++) begin
				tin[k][s]  = '0;
				tout[k][s] = '0;
			end
		end
		for (int pass = 0; pass < 4; pass++) begin
			for (int k = 0; k < 4; k++) begin
				r = k / 2;
				c = k % 2;
				if (r == 0) tin[k][`SIDE_N] = north_in[4*c +: 4];
				else tin[k][`SIDE_N] = tout[k-2][`SIDE_S];
				if (r == 1) tin[k][`SIDE_S] = '0;
				else tin[k][`SIDE_S] = tout[k+2][`SIDE_N];
				if (c == 0) tin[k][`SIDE_W] = west_in[4*r +: 4];
				else tin[k][`SIDE_W] = tout[k-1][`SIDE_E];
				if (c == 1) tin[k][`SIDE_E] = '0;
				else tin[k][`SIDE_E] = tout[k+1][`SIDE_W];
			end
			for (int k = 0; k < 4; k++) begin
				for (int s = 0; s < 4; s++) begin
					for (int t = 0; t < 4; t++) begin
						if (sb_cfg[k][4*s+t] == 2'd3) tout[k][s][t] = pe[k];
						else tout[k][s][t] = tin[k][(s+2)%4][t]; // Opposite side.
					end
				end
			end
		end
		for (int k = 0; k < 4; k++) begin
			op_a[k] = cb0_sel[k][2] ? tout[k][`SIDE_N][cb0_sel[k][1:0]]
				: tin[k][`SIDE_N][cb0_sel[k][1:0]];
			op_b[k] = cb1_sel[k][2] ? tout[k][`SIDE_W][cb1_sel[k][1:0]]
				: tin[k][`SIDE_W][cb1_sel[k][1:0]];
		end
		exp_south = {tout[3][`SIDE_S], tout[2][`SIDE_S]};
		exp_east  = {tout[3][`SIDE_E], tout[1][`SIDE_E]};
	end

endmodule

// ==== testbench/tb_cgra_array.sv ====
`include "cgra_consts.svh"

module tb_cgra_array;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 3000; // About 2400 cycles of tests plus margin.

	logic        clk;
	logic        rst_n;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	logic [7:0]  north_in;
	logic [7:0]  west_in;
	logic [7:0]  south_out;
	logic [7:0]  east_out;
	logic [7:0]  exp_south;
	logic [7:0]  exp_east;
	logic [31:0] rng_state;
	int          cycle_count = 0;

	cgra_array uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_addr (config_addr),
		.config_data (config_data),
		.north_in    (north_in),
		.west_in     (west_in),
		.south_out   (south_out),
		.east_out    (east_out)
	);

	tb_route_model model (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_addr (config_addr),
		.config_data (config_data),
		.north_in    (north_in),
		.west_in     (west_in),
		.exp_south   (exp_south),
		.exp_east    (exp_east)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Each set bit routes that output from the pe, a clear bit goes straight.
	function automatic logic [31:0] sb_word(input logic [15:0] pick);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w[2*i +: 2] = pick[i] ? 2'd3 : 2'd0;
		end
		return w;
	endfunction

	task automatic report_mismatch(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		$display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, expected);
		$display("STATUS: FAIL");
		$fatal(1, "output mismatch");
	endtask

	task automatic config_write(input logic [15:0] target, input logic [15:0] tile,
		input logic [31:0] data);
		config_addr = {target, tile};
		config_data = data;
		@(negedge clk);
		config_addr = '0; // Idle.
	endtask

	task automatic drive_random_inputs(input int cycles);
		logic [31:0] r;
		repeat (cycles) begin
			r = next_random();
			north_in = r[31:24];
			west_in  = r[23:16];
			@(negedge clk);
		end
	endtask

	task automatic apply_operands(input logic a, input logic b);
		logic [31:0] r;
		r = next_random();
		north_in    = r[7:0];
		west_in     = r[15:8];
		north_in[5] = a; // Tile 4 cb0, north track 1.
		west_in[6]  = b; // Tile 4 cb1, west track 2.
		@(negedge clk);
	endtask

	task automatic random_config();
		logic [31:0] r;
		logic [31:0] junk;
		logic [15:0] tile;
		r    = next_random();
		junk = next_random(); // Also fills the unused bits.
		tile = {14'd0, r[29:28]} + 16'd1;
		case (r[31:30])
			2'd0:    config_write(`CFG_SB, tile, sb_word(junk[31:16]));
			2'd1:    config_write(`CFG_CB0, tile, {junk[31:3], 1'b0, r[27:26]});
			2'd2:    config_write(`CFG_CB1, tile, {junk[31:3], 1'b0, r[27:26]});
			default: config_write(`CFG_CLB, tile, {junk[31:2], r[27:26]});
		endcase
	endtask

	a_south_out : assert property (
		@(posedge clk) disable iff (!rst_n) south_out == exp_south
	) else report_mismatch("south_out", $sampled(south_out), $sampled(exp_south));

	a_east_out : assert property (
		@(posedge clk) disable iff (!rst_n) east_out == exp_east
	) else report_mismatch("east_out", $sampled(east_out), $sampled(exp_east));

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rng_state   = 32'ha57d954e;
		rst_n       = 1'b0;
		config_addr = '0;
		config_data = '0;
		north_in    = '0;
		west_in     = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		drive_random_inputs(20); // Straight through both tiles.

		// Tile 4 ANDs north track 1 with west track 2 onto its east side.
		config_write(`CFG_CB0, 16'd4, 32'd1);
		config_write(`CFG_CB1, 16'd4, 32'd2);
		config_write(`CFG_CLB, 16'd4, 32'd0);
		config_write(`CFG_SB, 16'd4, 32'hff00_0000);
		drive_random_inputs(20);

		for (int code = 0; code < 4; code++) begin
			config_write(`CFG_CLB, 16'd4, 32'(code));
			for (int v = 0; v < 4; v++) begin
				apply_operands(v[0], v[1]);
			end
			drive_random_inputs(2);
		end

		// Tile 1 feeds its pe back on west track 0, seen on east track 0.
		config_write(`CFG_SB, 16'd1, 32'h0300_0300);
		config_write(`CFG_CB1, 16'd1, 32'd4);
		config_write(`CFG_CLB, 16'd1, 32'd2);
		north_in = 8'h01;
		west_in  = 8'h00;
		repeat (6) @(negedge clk);
		drive_random_inputs(12);

		// Writes that must not land anywhere.
		config_write(`CFG_SB, 16'd5, next_random());
		config_write(`CFG_SB, 16'd0, next_random());
		config_write(16'd3, 16'd1, next_random());
		config_write(16'd8, 16'd2, next_random());
		config_write(16'd0, 16'd0, next_random());
		drive_random_inputs(10);

		for (int n = 0; n < 200; n++) begin
			random_config();
			drive_random_inputs(10);
		end

		@(negedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+hw
hw/cgra_pkg.sv
hw/connect_box.sv
hw/switch_box.sv
hw/clb.sv
hw/pe_tile.sv
hw/cgra_array.sv
testbench/tb_route_model.sv
testbench/tb_cgra_array.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the CGRA testbench with Verilator, then checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f project.f --top-module tb_cgra_array -o sim_cgra \
	&& ./obj_dir/sim_cgra > sim.log 2>&1 \
	|| echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed"; exit 1; }
